// ==== rtl/cam_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and constants for the single camera tracker
// pixels are stored as rgb444, the filter picks one dominant channel
//////////////////////////////////////////////////////////////////////

package cam_pkg;

  // stored pixel, red in the top nibble
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  // colour selected by the button
  typedef enum logic [1:0] {
    FILT_RED   = 2'd0,
    FILT_GREEN = 2'd1,
    FILT_BLUE  = 2'd2
  } filter_t;

  localparam int NB_CAMDATA   = 8;  // ov7670 data bus
  localparam int COLOR_MARGIN = 4;  // min lead of the chosen channel
  localparam int PROX_LEVELS  = 8;  // proximity steps, 3 bit output

  // true when the chosen channel beats both others by the margin
  function automatic logic is_color(rgb444_t pxl, filter_t filt);
    int sel;
    int oth_a;
    int oth_b;
    case (filt)
      FILT_GREEN: begin
        sel   = int'(pxl.green);
        oth_a = int'(pxl.red);
        oth_b = int'(pxl.blue);
      end
      FILT_BLUE: begin
        sel   = int'(pxl.blue);
        oth_a = int'(pxl.red);
        oth_b = int'(pxl.green);
      end
      default: begin  // red
        sel   = int'(pxl.red);
        oth_a = int'(pxl.green);
        oth_b = int'(pxl.blue);
      end
    endcase
    return (sel >= oth_a + COLOR_MARGIN) && (sel >= oth_b + COLOR_MARGIN);
  endfunction

endpackage

// ==== rtl/frame_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// simple dual port ram, read data one cycle after addrb_i
// no reset, contents undefined until written
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module frame_buffer #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 19200,
  localparam int NB_ADDR   = $clog2(DEPTH)
) (
  input  logic               clk_i,
  // write side
  input  logic               wea_i,
  input  logic [NB_ADDR-1:0] addra_i,
  input  payload_t           dina_i,
  // read side
  input  logic [NB_ADDR-1:0] addrb_i,
  output payload_t           doutb_o
);

  payload_t mem [DEPTH];  // maps to block ram

  always_ff @(posedge clk_i) begin
    if (wea_i)
      mem[addra_i] <= dina_i;
  end

  // registered read, old data on same address collision
  always_ff @(posedge clk_i) begin
    doutb_o <= mem[addrb_i];
  end

endmodule

// ==== rtl/serial_divider.sv ====
//////////////////////////////////////////////////////////////////////
// restoring divider, WIDTH+1 cycles from start_i to done_o
// zero divisor gives all ones, start_i while busy is dropped
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module serial_divider #(
  parameter int WIDTH = 16
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic [WIDTH-1:0] dividend_i,
  input  logic [WIDTH-1:0] divisor_i,
  output logic [WIDTH-1:0] quotient_o,
  output logic             done_o
);

  localparam int NB_STEP = $clog2(WIDTH + 1);

  logic               busy;
  logic [NB_STEP-1:0] step_cnt;  // remaining quotient bits
  logic [WIDTH-1:0]   rem;
  logic [WIDTH-1:0]   quo;       // dividend shifts out, quotient in
  logic [WIDTH-1:0]   dvs;
  logic [WIDTH:0]     trial;     // partial remainder with next bit
  logic               fits;

  assign trial = {rem, quo[WIDTH-1]};
  assign fits  = trial >= {1'b0, dvs};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy) begin
        busy     <= 1'b1;
        step_cnt <= NB_STEP'(WIDTH);
      end else if (busy) begin
        step_cnt <= step_cnt - 1'b1;
        if (step_cnt == NB_STEP'(1)) begin
          busy   <= 1'b0;
          done_o <= 1'b1;  // last bit lands this edge
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy) begin
      rem <= '0;
      quo <= dividend_i;
      dvs <= divisor_i;
    end else if (busy) begin
      if (fits) begin
        rem <= WIDTH'(trial - {1'b0, dvs});  // result below dvs, fits
        quo <= {quo[WIDTH-2:0], 1'b1};
      end else begin
        rem <= trial[WIDTH-1:0];
        quo <= {quo[WIDTH-2:0], 1'b0};
      end
    end
  end

  assign quotient_o = quo;

endmodule

// ==== rtl/cam_capture.sv ====
//////////////////////////////////////////////////////////////////////
// cam_pclk_i must run at most a quarter of the clk_i rate
// frame_done_o pulses only for frames of exactly IMG_COLS*IMG_ROWS
// rgb565 byte pairs are cut down to rgb444 pixels
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cam_capture
  import cam_pkg::*;
#(
  parameter int IMG_COLS = 160,
  parameter int IMG_ROWS = 120,
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS,
  localparam int NB_ADDR  = $clog2(IMG_PXLS)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cam_pclk_i,
  input  logic                  cam_vsync_i,
  input  logic                  cam_href_i,
  input  logic [NB_CAMDATA-1:0] cam_data_i,
  output logic                  wr_en_o,
  output logic [NB_ADDR-1:0]    wr_addr_o,
  output rgb444_t               wr_data_o,
  output logic                  frame_done_o
);

  localparam int NB_CNT = $clog2(IMG_PXLS + 1);  // must hold IMG_PXLS itself

  logic [2:0]            pclk_sr;   // 2 sync stages + edge reg
  logic [2:0]            vsync_sr;
  logic [1:0]            href_sr;
  logic [NB_CAMDATA-1:0] data_s1;
  logic [NB_CAMDATA-1:0] data_s2;   // aligned with pclk_sr[1]
  logic [NB_CAMDATA-1:0] first_byte;
  logic                  byte_ph;   // low on the first byte of a pair
  logic [NB_CNT-1:0]     pxl_cnt;
  logic                  overrun;   // more pixels than the image holds
  logic                  pclk_rise;
  logic                  vsync_rise;
  logic                  byte_take;

  assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
  assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];
  assign byte_take  = pclk_rise & href_sr[1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pclk_sr      <= '0;
      vsync_sr     <= '0;
      href_sr      <= '0;
      byte_ph      <= 1'b0;
      pxl_cnt      <= '0;
      overrun      <= 1'b0;
      wr_en_o      <= 1'b0;
      wr_addr_o    <= '0;
      frame_done_o <= 1'b0;
    end else begin
      pclk_sr      <= {pclk_sr[1:0], cam_pclk_i};
      vsync_sr     <= {vsync_sr[1:0], cam_vsync_i};
      href_sr      <= {href_sr[0], cam_href_i};
      wr_en_o      <= 1'b0;
      frame_done_o <= 1'b0;
      if (vsync_rise) begin
        // report the old frame only when complete
        frame_done_o <= (pxl_cnt == NB_CNT'(IMG_PXLS)) && !overrun;
        pxl_cnt      <= '0;
        overrun      <= 1'b0;
        byte_ph      <= 1'b0;
      end else if (!href_sr[1]) begin
        byte_ph <= 1'b0;  // resync pairs on each line
      end else if (byte_take) begin
        byte_ph <= ~byte_ph;
        if (byte_ph) begin
          if (pxl_cnt == NB_CNT'(IMG_PXLS)) begin
            overrun <= 1'b1;  // drop pixels of a long frame
          end else begin
            wr_en_o   <= 1'b1;
            wr_addr_o <= pxl_cnt[NB_ADDR-1:0];
            pxl_cnt   <= pxl_cnt + 1'b1;
          end
        end
      end
    end
  end

  // byte alignment and pixel assembly
  always_ff @(posedge clk_i) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
    if (byte_take && !byte_ph)
      first_byte <= data_s2;  // r[7:3] g_hi[2:0]
    if (byte_take && byte_ph) begin
      wr_data_o.red   <= first_byte[7:4];
      wr_data_o.green <= {first_byte[2:0], data_s2[7]};
      wr_data_o.blue  <= data_s2[4:1];  // drop blue lsb
    end
  end

endmodule

// ==== rtl/color_proc.sv ====
//////////////////////////////////////////////////////////////////////
// sweeps the stored frame after frame_done_i, frame_done while busy is lost
// centroid and proximity hold until the next new_centroid_o pulse
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module color_proc
  import cam_pkg::*;
#(
  parameter int IMG_COLS = 160,
  parameter int IMG_ROWS = 120,
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS,
  localparam int NB_ADDR  = $clog2(IMG_PXLS),
  localparam int NB_COLS  = $clog2(IMG_COLS),
  localparam int NB_PROX  = $clog2(PROX_LEVELS)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               proc_ctrl_i,   // filter button
  input  logic               frame_done_i,
  // original frame
  output logic [NB_ADDR-1:0] orig_addr_o,
  input  rgb444_t            orig_pxl_i,
  // mask frame
  output logic               mask_we_o,
  output logic [NB_ADDR-1:0] mask_addr_o,
  output logic               mask_bit_o,
  // results
  output filter_t            rgbfilter_o,
  output logic [NB_COLS-1:0] centroid_o,
  output logic [NB_PROX-1:0] proximity_o,
  output logic               new_centroid_o
);

  localparam int NB_CNT = $clog2(IMG_PXLS + 1);
  // wide enough for column sum and count*PROX_LEVELS
  localparam int DIV_W  = $clog2(IMG_PXLS * (IMG_COLS + PROX_LEVELS));

  typedef enum logic [1:0] {ST_IDLE, ST_SWEEP, ST_CENT, ST_PROX} state_t;

  state_t             state;
  logic [2:0]         btn_sr;     // 2 sync stages + edge reg
  filter_t            filt_lat;   // filter used by the running sweep
  logic               rd_act;     // address phase of the sweep
  logic [NB_ADDR-1:0] rd_addr;
  logic [NB_COLS-1:0] rd_col;
  logic               pxl_vld;    // orig_pxl_i valid this cycle
  logic [NB_ADDR-1:0] pxl_addr;
  logic [NB_COLS-1:0] pxl_col;
  logic               pxl_last;
  logic               pxl_match;
  logic [NB_CNT-1:0]  match_cnt;
  logic [DIV_W-1:0]   col_sum;
  logic [DIV_W-1:0]   cnt_ext;
  logic [NB_COLS-1:0] cent_q;     // centroid waits for proximity
  logic               div_start;
  logic [DIV_W-1:0]   div_dividend;
  logic [DIV_W-1:0]   div_divisor;
  logic [DIV_W-1:0]   div_quot;
  logic               div_done;

  assign orig_addr_o = rd_addr;
  assign pxl_match   = is_color(orig_pxl_i, filt_lat);
  assign mask_we_o   = pxl_vld;
  assign mask_addr_o = pxl_addr;
  assign mask_bit_o  = pxl_match;
  assign cnt_ext     = DIV_W'(match_cnt);

  // first run centroid, second run proximity
  assign div_dividend = (state == ST_CENT) ? col_sum : cnt_ext * DIV_W'(PROX_LEVELS);
  assign div_divisor  = (state == ST_CENT) ? cnt_ext : DIV_W'(IMG_PXLS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state          <= ST_IDLE;
      btn_sr         <= '0;
      rgbfilter_o    <= FILT_RED;
      filt_lat       <= FILT_RED;
      rd_act         <= 1'b0;
      rd_addr        <= '0;
      rd_col         <= '0;
      pxl_vld        <= 1'b0;
      match_cnt      <= '0;
      col_sum        <= '0;
      div_start      <= 1'b0;
      centroid_o     <= '0;
      proximity_o    <= '0;
      new_centroid_o <= 1'b0;
    end else begin
      btn_sr         <= {btn_sr[1:0], proc_ctrl_i};
      div_start      <= 1'b0;
      new_centroid_o <= 1'b0;
      if (btn_sr[1] && !btn_sr[2]) begin
        case (rgbfilter_o)  // red -> green -> blue -> red
          FILT_RED:   rgbfilter_o <= FILT_GREEN;
          FILT_GREEN: rgbfilter_o <= FILT_BLUE;
          default:    rgbfilter_o <= FILT_RED;
        endcase
      end
      // address phase
      pxl_vld <= rd_act;
      if (rd_act) begin
        rd_addr <= rd_addr + 1'b1;
        rd_col  <= (rd_col == NB_COLS'(IMG_COLS - 1)) ? '0 : rd_col + 1'b1;
        if (rd_addr == NB_ADDR'(IMG_PXLS - 1))
          rd_act <= 1'b0;
      end
      // data phase, one cycle behind
      if (pxl_vld && pxl_match) begin
        match_cnt <= match_cnt + 1'b1;
        col_sum   <= col_sum + DIV_W'(pxl_col);
      end
      case (state)
        ST_IDLE: begin
          if (frame_done_i) begin
            state     <= ST_SWEEP;
            filt_lat  <= rgbfilter_o;
            rd_act    <= 1'b1;
            rd_addr   <= '0;
            rd_col    <= '0;
            match_cnt <= '0;
            col_sum   <= '0;
          end
        end
        ST_SWEEP: begin
          if (pxl_vld && pxl_last) begin
            state     <= ST_CENT;
            div_start <= 1'b1;  // sums are final next cycle
          end
        end
        ST_CENT: begin
          if (div_done) begin
            cent_q    <= (match_cnt == '0) ? '0 : div_quot[NB_COLS-1:0];
            state     <= ST_PROX;
            div_start <= 1'b1;
          end
        end
        default: begin  // ST_PROX
          if (div_done) begin
            centroid_o     <= cent_q;
            proximity_o    <= (div_quot >= DIV_W'(PROX_LEVELS - 1)) ?
                              NB_PROX'(PROX_LEVELS - 1) : div_quot[NB_PROX-1:0];
            new_centroid_o <= 1'b1;
            state          <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // pipeline payload, qualified by pxl_vld
  always_ff @(posedge clk_i) begin
    pxl_addr <= rd_addr;
    pxl_col  <= rd_col;
    pxl_last <= (rd_addr == NB_ADDR'(IMG_PXLS - 1));
  end

  serial_divider #(
    .WIDTH      (DIV_W)
  ) u_serial_divider (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .dividend_i (div_dividend),
    .divisor_i  (div_divisor),
    .quotient_o (div_quot),
    .done_o     (div_done)
  );

endmodule

// ==== rtl/cam_track_top.sv ====
//////////////////////////////////////////////////////////////////////
// one ov7670 path on a single clock, camera pins are asynchronous
// mask buffer is read back through mask_addr_i, one cycle latency
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cam_track_top
  import cam_pkg::*;
#(
  parameter int IMG_COLS = 160,
  parameter int IMG_ROWS = 120,
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS,
  localparam int NB_ADDR  = $clog2(IMG_PXLS),
  localparam int NB_COLS  = $clog2(IMG_COLS),
  localparam int NB_PROX  = $clog2(PROX_LEVELS)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // camera
  input  logic                  cam_pclk_i,
  input  logic                  cam_vsync_i,
  input  logic                  cam_href_i,
  input  logic [NB_CAMDATA-1:0] cam_data_i,
  input  logic                  proc_ctrl_i,   // filter button
  // mask readback
  input  logic [NB_ADDR-1:0]    mask_addr_i,
  output logic                  mask_o,
  // tracking results
  output filter_t               rgbfilter_o,
  output logic [NB_COLS-1:0]    centroid_o,
  output logic [NB_PROX-1:0]    proximity_o,
  output logic                  new_centroid_o
);

  logic               cap_we;
  logic [NB_ADDR-1:0] cap_addr;
  rgb444_t            cap_data;
  logic               frame_done;
  logic [NB_ADDR-1:0] orig_addr;
  rgb444_t            orig_pxl;
  logic               mask_we;
  logic [NB_ADDR-1:0] mask_wr_addr;
  logic               mask_bit;

  cam_capture #(
    .IMG_COLS     (IMG_COLS),
    .IMG_ROWS     (IMG_ROWS)
  ) u_cam_capture (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_vsync_i  (cam_vsync_i),
    .cam_href_i   (cam_href_i),
    .cam_data_i   (cam_data_i),
    .wr_en_o      (cap_we),
    .wr_addr_o    (cap_addr),
    .wr_data_o    (cap_data),
    .frame_done_o (frame_done)
  );

  // frame as captured
  frame_buffer #(
    .payload_t (rgb444_t),
    .DEPTH     (IMG_PXLS)
  ) orig_fb (
    .clk_i     (clk_i),
    .wea_i     (cap_we),
    .addra_i   (cap_addr),
    .dina_i    (cap_data),
    .addrb_i   (orig_addr),
    .doutb_o   (orig_pxl)
  );

  color_proc #(
    .IMG_COLS       (IMG_COLS),
    .IMG_ROWS       (IMG_ROWS)
  ) u_color_proc (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .proc_ctrl_i    (proc_ctrl_i),
    .frame_done_i   (frame_done),
    .orig_addr_o    (orig_addr),
    .orig_pxl_i     (orig_pxl),
    .mask_we_o      (mask_we),
    .mask_addr_o    (mask_wr_addr),
    .mask_bit_o     (mask_bit),
    .rgbfilter_o    (rgbfilter_o),
    .centroid_o     (centroid_o),
    .proximity_o    (proximity_o),
    .new_centroid_o (new_centroid_o)
  );

  // one match bit per pixel
  frame_buffer #(
    .payload_t (logic),
    .DEPTH     (IMG_PXLS)
  ) mask_fb (
    .clk_i     (clk_i),
    .wea_i     (mask_we),
    .addra_i   (mask_wr_addr),
    .dina_i    (mask_bit),
    .addrb_i   (mask_addr_i),
    .doutb_o   (mask_o)
  );

endmodule

// ==== include/tb_frame_table.svh ====
//////////////////////////////////////////////////////////////////////
// test frames for an 8x4 image, columns 0..7 and rows 0..3
// exp_filt is the filter expected after the presses of that row
//////////////////////////////////////////////////////////////////////
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

typedef struct packed {
  int      presses;     // button presses before the frame
  filter_t exp_filt;
  filter_t obj_color;   // object is pure colour
  int      c0;          // object columns c0..c1
  int      c1;
  int      r0;          // object rows r0..r1
  int      r1;
  bit      dec_en;      // second block of another colour
  filter_t dec_color;
  int      dc0;
  int      dc1;
  int      dr0;
  int      dr1;
  bit      rand_bg;     // lfsr background, else grey
  bit      short_frm;   // short frame sent first
} frame_row_t;

localparam int NROWS = 8;

// presses, exp_filt, obj colour, c0 c1 r0 r1, decoy en, colour, c0 c1 r0 r1, rand, short
localparam frame_row_t FRAME_TABLE [NROWS] = '{
  '{0, FILT_RED,   FILT_RED,   0, 7, 0, 3, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b0, 1'b0},
  '{0, FILT_RED,   FILT_RED,   5, 7, 0, 3, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b0, 1'b0},
  // blue block only, nothing red
  '{0, FILT_RED,   FILT_BLUE,  2, 4, 1, 2, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b0, 1'b0},
  '{1, FILT_GREEN, FILT_GREEN, 5, 6, 1, 2, 1'b1, FILT_RED, 0, 2, 0, 3, 1'b0, 1'b0},
  '{0, FILT_GREEN, FILT_GREEN, 1, 2, 0, 1, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b1, 1'b0},
  '{1, FILT_BLUE,  FILT_BLUE,  3, 5, 2, 3, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b1, 1'b0},
  '{1, FILT_RED,   FILT_RED,   2, 3, 0, 3, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b0, 1'b1},
  '{0, FILT_RED,   FILT_RED,   0, 0, 0, 0, 1'b0, FILT_RED, 0, 0, 0, 0, 1'b1, 1'b1}
};

`endif

// ==== test/tb_cam_track.sv ====
//////////////////////////////////////////////////////////////////////
// 8x4 image with one result strobe expected per table row
// stops at the first mismatch or once the cycle limit is reached
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cam_track
  import cam_pkg::*;
();

  localparam int IMG_COLS = 8;
  localparam int IMG_ROWS = 4;
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS;
  localparam int NB_ADDR  = $clog2(IMG_PXLS);

  `include "tb_frame_table.svh"

  // two frames per row when a short frame goes first
  localparam int FRAME_CYC   = IMG_PXLS * 2 * 4;
  localparam int ROW_CYC     = 2 * FRAME_CYC + IMG_PXLS + 1 + 2 * 33;
  localparam int TIMEOUT_CYC = NROWS * (ROW_CYC + 300) + 500;  // gaps, presses, readback

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        cam_pclk_i;
  logic                        cam_vsync_i;
  logic                        cam_href_i;
  logic [NB_CAMDATA-1:0]       cam_data_i;
  logic                        proc_ctrl_i;
  logic [NB_ADDR-1:0]          mask_addr_i;
  logic                        mask_o;
  filter_t                     rgbfilter_o;
  logic [$clog2(IMG_COLS)-1:0] centroid_o;
  logic [2:0]                  proximity_o;
  logic                        new_centroid_o;

  rgb444_t     frame [IMG_PXLS];  // pixels of the frame being sent
  logic [31:0] lfsr_state = 32'ha5a7;
  int          cycle_cnt = 0;
  int          pulse_cnt = 0;     // new_centroid_o strobes seen
  int          exp_cent;
  int          exp_prox;
  int          start_cnt;
  frame_row_t  row;

  cam_track_top #(
    .IMG_COLS (IMG_COLS),
    .IMG_ROWS (IMG_ROWS)
  ) u_cam_track_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (new_centroid_o)
      pulse_cnt <= pulse_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout, no result strobe after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "simulation hung");
    end
  end

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_pixel(output rgb444_t p);
    logic [11:0] v;
    v = '0;
    for (int i = 0; i < 12; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      v = {v[10:0], lfsr_state[0]};
    end
    p = v;
  endtask

  function automatic rgb444_t pure_color(filter_t f);
    case (f)
      FILT_GREEN: return 12'h0f0;
      FILT_BLUE:  return 12'h00f;
      default:    return 12'hf00;
    endcase
  endfunction

  // selected channel must lead every other channel by the margin
  function automatic bit expect_match(rgb444_t p, filter_t f);
    int ch [3];
    int s;
    bit ok;
    ch[0] = int'(p.red);
    ch[1] = int'(p.green);
    ch[2] = int'(p.blue);
    case (f)
      FILT_GREEN: s = 1;
      FILT_BLUE:  s = 2;
      default:    s = 0;
    endcase
    ok = 1'b1;
    for (int i = 0; i < 3; i++)
      if (i != s && ch[s] < ch[i] + COLOR_MARGIN)
        ok = 1'b0;
    return ok;
  endfunction

  task automatic build_frame(frame_row_t t);
    int col;
    int r;
    for (int a = 0; a < IMG_PXLS; a++) begin
      col = a % IMG_COLS;
      r   = a / IMG_COLS;
      if (col >= t.c0 && col <= t.c1 && r >= t.r0 && r <= t.r1)
        frame[a] = pure_color(t.obj_color);
      else if (t.dec_en && col >= t.dc0 && col <= t.dc1 && r >= t.dr0 && r <= t.dr1)
        frame[a] = pure_color(t.dec_color);
      else if (t.rand_bg)
        random_pixel(frame[a]);
      else
        frame[a] = 12'h888;  // grey never matches
    end
  endtask

  task automatic compute_expected(filter_t f);
    int cnt;
    int sum;
    cnt = 0;
    sum = 0;
    for (int a = 0; a < IMG_PXLS; a++) begin
      if (expect_match(frame[a], f)) begin
        cnt++;
        sum += a % IMG_COLS;
      end
    end
    exp_cent = (cnt == 0) ? 0 : sum / cnt;
    exp_prox = cnt * PROX_LEVELS / IMG_PXLS;
    if (exp_prox > PROX_LEVELS - 1)
      exp_prox = PROX_LEVELS - 1;
  endtask

  // one pclk period of 4 clk with data changing while pclk is low
  task automatic drive_pclk(logic [NB_CAMDATA-1:0] d, logic href, logic vs);
    @(negedge clk_i);
    cam_pclk_i  = 1'b0;
    cam_data_i  = d;
    cam_href_i  = href;
    cam_vsync_i = vs;
    @(negedge clk_i);
    @(negedge clk_i);
    cam_pclk_i = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic send_rows(int nrows);
    rgb444_t p;
    for (int r = 0; r < nrows; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        p = frame[r * IMG_COLS + c];
        drive_pclk({p.red, 1'b1, p.green[3:1]}, 1'b1, 1'b0);  // junk in dropped bits
        drive_pclk({p.green[0], 2'b10, p.blue, 1'b1}, 1'b1, 1'b0);
      end
      repeat (2) drive_pclk('0, 1'b0, 1'b0);  // line blank
    end
  endtask

  task automatic vsync_pulse();
    repeat (2) drive_pclk('0, 1'b0, 1'b1);
    repeat (2) drive_pclk('0, 1'b0, 1'b0);
  endtask

  task automatic press_button();
    @(negedge clk_i);
    proc_ctrl_i = 1'b1;
    repeat (4) @(negedge clk_i);
    proc_ctrl_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    cam_pclk_i  = 1'b0;
    cam_vsync_i = 1'b0;
    cam_href_i  = 1'b0;
    cam_data_i  = '0;
    proc_ctrl_i = 1'b0;
    mask_addr_i = '0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk_i);
    check_eq("rgbfilter_o", 32'(FILT_RED), 32'(rgbfilter_o));
    check_eq("centroid_o", 0, 32'(centroid_o));
    check_eq("proximity_o", 0, 32'(proximity_o));
    check_eq("new_centroid_o", 0, 32'(new_centroid_o));
    for (int i = 0; i < NROWS; i++) begin
      row = FRAME_TABLE[i];
      repeat (row.presses) press_button();
      check_eq("rgbfilter_o", 32'(row.exp_filt), 32'(rgbfilter_o));
      build_frame(row);
      compute_expected(row.exp_filt);
      start_cnt = pulse_cnt;
      if (row.short_frm) begin
        send_rows(IMG_ROWS - 1);  // last line missing
        vsync_pulse();
      end
      send_rows(IMG_ROWS);
      check_eq("new_centroid_o pulses", start_cnt, pulse_cnt);
      vsync_pulse();
      while (pulse_cnt == start_cnt)
        @(negedge clk_i);
      check_eq("centroid_o", exp_cent, 32'(centroid_o));
      check_eq("proximity_o", exp_prox, 32'(proximity_o));
      // read the mask back with one cycle of latency
      for (int a = 0; a < IMG_PXLS; a++) begin
        @(negedge clk_i);
        mask_addr_i = NB_ADDR'(a);
        @(negedge clk_i);
        check_eq("mask_o", 32'(expect_match(frame[a], row.exp_filt)), 32'(mask_o));
      end
      check_eq("new_centroid_o pulses", start_cnt + 1, pulse_cnt);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
rtl/cam_pkg.sv
rtl/frame_buffer.sv
rtl/serial_divider.sv
rtl/cam_capture.sv
rtl/color_proc.sv
rtl/cam_track_top.sv
test/tb_cam_track.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera tracker testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps -f all.f \
  --top-module tb_cam_track -o sim_cam_track
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_cam_track)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1
